//--- logic/gpu_cfg.svh
// One fixed build configuration, and GPU_NUM_LANES must stay equal to cores times block size
`ifndef GPU_CFG_SVH
`define GPU_CFG_SVH

// Compute resources
`define GPU_NUM_CORES          2
`define GPU_THREADS_PER_BLOCK  4
`define GPU_NUM_LANES          (`GPU_NUM_CORES * `GPU_THREADS_PER_BLOCK)

// Data memory geometry
`define GPU_DATA_ADDR_BITS     8
`define GPU_DATA_BITS          8

// Program memory geometry
`define GPU_PROG_ADDR_BITS     8
`define GPU_INSTR_BITS         16

`endif

//--- logic/gpu_pkg.sv
// Widths follow gpu_cfg.svh and the instruction fields are fixed at four bits each
`include "gpu_cfg.svh"

package gpu_pkg;

    typedef logic [`GPU_DATA_BITS-1:0]      data_t;
    typedef logic [`GPU_DATA_ADDR_BITS-1:0] daddr_t;
    typedef logic [`GPU_PROG_ADDR_BITS-1:0] paddr_t;
    typedef logic [`GPU_INSTR_BITS-1:0]     instr_t;
    typedef logic [7:0]                     block_id_t;
    typedef logic [3:0]                     reg_idx_t;

    // Counts 0 up to a full block
    typedef logic [$clog2(`GPU_THREADS_PER_BLOCK):0] lane_count_t;

    // Codes not listed here behave as NOP
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd3,
        OP_SUB   = 4'd4,
        OP_MUL   = 4'd5,
        OP_LDR   = 4'd7,
        OP_STR   = 4'd8,
        OP_CONST = 4'd9,
        OP_RET   = 4'd15
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        REQUEST,
        WAIT,
        EXECUTE,
        UPDATE
    } core_state_e;

endpackage

//--- logic/block_dispatch.sv
// Start is only taken while every core is idle, and the thread count is written before start
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module block_dispatch (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      start,
    input  logic                                      dcr_write,
    input  gpu_pkg::data_t                            dcr_data,
    input  logic [`GPU_NUM_CORES-1:0]                 core_done,
    output logic [`GPU_NUM_CORES-1:0]                 core_start,
    output gpu_pkg::block_id_t [`GPU_NUM_CORES-1:0]   core_block_id,
    output gpu_pkg::lane_count_t [`GPU_NUM_CORES-1:0] core_thread_count,
    output logic                                      done
);
    import gpu_pkg::*;

    localparam int TPB       = `GPU_THREADS_PER_BLOCK;
    localparam int BLK_BITS  = $clog2(TPB);
    localparam int CORE_BITS = (`GPU_NUM_CORES > 1) ? $clog2(`GPU_NUM_CORES) : 1;

    // Device control register
    data_t                     thread_count_q;

    block_id_t                 total_blocks;
    block_id_t                 next_block;
    block_id_t                 blocks_done;
    logic                      running;
    logic [`GPU_NUM_CORES-1:0] busy;

    block_id_t                 calc_blocks;
    block_id_t                 cur_total;
    block_id_t                 cur_next;
    block_id_t                 done_sum;
    lane_count_t               tail_count;
    logic                      issue_en;
    logic [CORE_BITS-1:0]      issue_core;

    // Blocks needed, a partial block rounds up
    assign calc_blocks = block_id_t'(({1'b0, thread_count_q} + 9'(TPB - 1)) >> BLK_BITS);

    // Last block only carries the remainder
    assign tail_count = (thread_count_q[BLK_BITS-1:0] == '0) ?
                        lane_count_t'(TPB) : lane_count_t'(thread_count_q[BLK_BITS-1:0]);

    // The start cycle already dispatches from the new block range
    assign cur_total = start ? calc_blocks : total_blocks;
    assign cur_next  = start ? '0 : next_block;

    always_comb begin
        issue_en   = 1'b0;
        issue_core = '0;
        done_sum   = blocks_done;
        // Downward walk so the lowest idle core is kept
        for (int c = `GPU_NUM_CORES - 1; c >= 0; c--) begin
            if ((start || running) && (cur_next != cur_total) && !busy[c]) begin
                issue_en   = 1'b1;
                issue_core = CORE_BITS'(c);
            end
        end
        for (int c = 0; c < `GPU_NUM_CORES; c++) begin
            done_sum = done_sum + block_id_t'(core_done[c]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            thread_count_q <= '0;
            total_blocks   <= '0;
            next_block     <= '0;
            blocks_done    <= '0;
            running        <= 1'b0;
            busy           <= '0;
            core_start     <= '0;
            done           <= 1'b0;
        end else begin
            core_start <= '0;
            busy       <= busy & ~core_done;
            next_block <= cur_next;
            if (dcr_write) begin
                thread_count_q <= dcr_data;
            end
            if (start) begin
                total_blocks <= calc_blocks;
                blocks_done  <= '0;
                running      <= 1'b1;
                done         <= 1'b0;
            end else if (running) begin
                blocks_done <= done_sum;
                // all blocks back means all were dispatched
                if (done_sum == total_blocks) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
            if (issue_en) begin
                core_start[issue_core] <= 1'b1;
                busy[issue_core]       <= 1'b1;
                next_block             <= cur_next + 1'b1;
            end
        end
    end

    // Block parameters stay put until the core's next start
    always_ff @(posedge clk) begin
        if (issue_en) begin
            core_block_id[issue_core]     <= cur_next;
            core_thread_count[issue_core] <= (cur_next == cur_total - 1'b1) ?
                                             tail_count : lane_count_t'(TPB);
        end
    end

    // Cores only get work while idle and only report back while holding a block
    assert property (@(posedge clk) disable iff (!arst_n) (core_start & $past(busy)) == '0);
    assert property (@(posedge clk) disable iff (!arst_n) (core_done & ~busy) == '0);

endmodule

//--- logic/data_mem_arbiter.sv
// One memory transaction in flight at a time, and a new grant waits for the previous ready
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module data_mem_arbiter (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [`GPU_NUM_LANES-1:0]            lane_valid,
    input  logic [`GPU_NUM_LANES-1:0]            lane_write,
    input  gpu_pkg::daddr_t [`GPU_NUM_LANES-1:0] lane_address,
    input  gpu_pkg::data_t [`GPU_NUM_LANES-1:0]  lane_wdata,
    input  logic                                 mem_ready,
    input  gpu_pkg::data_t                       mem_rdata,
    output logic [`GPU_NUM_LANES-1:0]            lane_ready,
    output gpu_pkg::data_t [`GPU_NUM_LANES-1:0]  lane_rdata,
    output logic                                 mem_valid,
    output logic                                 mem_write,
    output gpu_pkg::daddr_t                      mem_address,
    output gpu_pkg::data_t                       mem_wdata
);
    localparam int LANE_BITS = $clog2(`GPU_NUM_LANES);

    logic [LANE_BITS-1:0]      last_q;
    logic [LANE_BITS-1:0]      cur_q;
    logic [LANE_BITS-1:0]      pick;
    logic [LANE_BITS-1:0]      cand;
    logic                      pick_en;
    logic [`GPU_NUM_LANES-1:0] served_q;
    logic [`GPU_NUM_LANES-1:0] pending;

    // The lane answered last cycle is still lowering its valid
    assign pending = lane_valid & ~served_q;

    always_comb begin
        pick_en = 1'b0;
        pick    = '0;
        cand    = '0;
        // Nearest lane after last_q wins, last_q itself comes last
        for (int off = `GPU_NUM_LANES; off >= 1; off--) begin
            cand = last_q + LANE_BITS'(off);
            if (pending[cand]) begin
                pick_en = 1'b1;
                pick    = cand;
            end
        end
    end

    always_comb begin
        lane_ready        = '0;
        lane_ready[cur_q] = mem_valid && mem_ready;
    end

    // Read data goes to every lane, only the one seeing ready takes it
    assign lane_rdata = {`GPU_NUM_LANES{mem_rdata}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_valid <= 1'b0;
            cur_q     <= '0;
            last_q    <= LANE_BITS'(`GPU_NUM_LANES - 1);
            served_q  <= '0;
        end else begin
            served_q <= '0;
            if (mem_valid) begin
                if (mem_ready) begin
                    mem_valid       <= 1'b0;
                    last_q          <= cur_q;
                    served_q[cur_q] <= 1'b1;
                end
            end else if (pick_en) begin
                mem_valid <= 1'b1;
                cur_q     <= pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_valid && pick_en) begin
            mem_write   <= lane_write[pick];
            mem_address <= lane_address[pick];
            mem_wdata   <= lane_wdata[pick];
        end
    end

    // Memory sees one unchanged request until it answers
    assert property (@(posedge clk) disable iff (!arst_n)
        mem_valid && !mem_ready |=> mem_valid && $stable({mem_write, mem_address, mem_wdata}));

endmodule

//--- logic/compute_core.sv
// No branches, so every lane follows the same path and each program must end in RET
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module compute_core (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         start,
    input  gpu_pkg::block_id_t                           block_id,
    input  gpu_pkg::lane_count_t                         thread_count,
    input  logic                                         prog_read_ready,
    input  gpu_pkg::instr_t                              prog_read_data,
    input  logic [`GPU_THREADS_PER_BLOCK-1:0]            lane_ready,
    input  gpu_pkg::data_t [`GPU_THREADS_PER_BLOCK-1:0]  lane_rdata,
    output logic                                         done,
    output logic                                         prog_read_valid,
    output gpu_pkg::paddr_t                              prog_read_address,
    output logic [`GPU_THREADS_PER_BLOCK-1:0]            lane_valid,
    output logic [`GPU_THREADS_PER_BLOCK-1:0]            lane_write,
    output gpu_pkg::daddr_t [`GPU_THREADS_PER_BLOCK-1:0] lane_address,
    output gpu_pkg::data_t [`GPU_THREADS_PER_BLOCK-1:0]  lane_wdata
);
    import gpu_pkg::*;

    localparam int TPB     = `GPU_THREADS_PER_BLOCK;
    localparam int NUM_GPR = 13;

    // Read-only registers above the general ones
    localparam reg_idx_t R_BLOCK_ID  = 4'd13;
    localparam reg_idx_t R_BLOCK_DIM = 4'd14;
    localparam reg_idx_t R_THREAD_ID = 4'd15;

    core_state_e    state;
    paddr_t         pc;
    instr_t         instr;
    opcode_e        op;
    reg_idx_t       rd;
    reg_idx_t       rs;
    reg_idx_t       rt;
    logic           writes_rd;
    logic [TPB-1:0] active;

    data_t          rf [TPB][NUM_GPR];
    data_t          load_q [TPB];
    data_t          result_q [TPB];
    data_t          rs_val [TPB];
    data_t          rt_val [TPB];

    function automatic data_t reg_read(input int lane, input reg_idx_t idx);
        case (idx)
            R_BLOCK_ID:  return data_t'(block_id);
            R_BLOCK_DIM: return data_t'(thread_count);
            R_THREAD_ID: return data_t'(lane);
            default:     return rf[lane][idx];
        endcase
    endfunction

    assign op = opcode_e'(instr[15:12]);
    assign rd = instr[11:8];
    assign rs = instr[7:4];
    assign rt = instr[3:0];

    assign writes_rd = op inside {OP_ADD, OP_SUB, OP_MUL, OP_LDR, OP_CONST};

    assign prog_read_valid   = (state == FETCH);
    assign prog_read_address = pc;
    assign done              = (state == UPDATE) && (op == OP_RET);

    always_comb begin
        for (int j = 0; j < TPB; j++) begin
            active[j]       = lane_count_t'(j) < thread_count;
            rs_val[j]       = reg_read(j, rs);
            rt_val[j]       = reg_read(j, rt);
            lane_write[j]   = (op == OP_STR);
            lane_address[j] = daddr_t'(rs_val[j]);
            lane_wdata[j]   = rt_val[j];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            pc         <= '0;
            lane_valid <= '0;
        end else begin
            // each lane drops its request right after its ready pulse
            lane_valid <= lane_valid & ~lane_ready;
            case (state)
                IDLE: begin
                    if (start) begin
                        pc    <= '0;
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (prog_read_ready) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    if (op == OP_LDR || op == OP_STR) begin
                        lane_valid <= active;
                        state      <= REQUEST;
                    end else begin
                        state <= EXECUTE;
                    end
                end
                REQUEST: state <= WAIT;
                WAIT: begin
                    if ((lane_valid & ~lane_ready) == '0) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: state <= UPDATE;
                UPDATE: begin
                    if (op == OP_RET) begin
                        state <= IDLE;
                    end else begin
                        pc    <= pc + 1'b1;
                        state <= FETCH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Datapath, arithmetic wraps at the word width
    always_ff @(posedge clk) begin
        if (state == FETCH && prog_read_ready) begin
            instr <= prog_read_data;
        end
        for (int j = 0; j < TPB; j++) begin
            if (lane_valid[j] && lane_ready[j]) begin
                load_q[j] <= lane_rdata[j];
            end
            if (state == EXECUTE) begin
                case (op)
                    OP_ADD:   result_q[j] <= rs_val[j] + rt_val[j];
                    OP_SUB:   result_q[j] <= rs_val[j] - rt_val[j];
                    OP_MUL:   result_q[j] <= rs_val[j] * rt_val[j];
                    OP_LDR:   result_q[j] <= load_q[j];
                    OP_CONST: result_q[j] <= instr[7:0];
                    default:  result_q[j] <= rs_val[j];
                endcase
            end
            // Inactive lanes and the read-only registers are never written
            if (state == UPDATE && writes_rd && active[j] && rd < reg_idx_t'(NUM_GPR)) begin
                rf[j][rd] <= result_q[j];
            end
        end
    end

    // Lane requests only belong to the memory phase of LDR and STR
    assert property (@(posedge clk) disable iff (!arst_n)
        (lane_valid != '0) |-> (state inside {REQUEST, WAIT}) && (op inside {OP_LDR, OP_STR}));

endmodule

//--- logic/gpu.sv
// Program memory has one read channel per core, data memory one shared channel
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module gpu (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 start,
    input  logic                                 dcr_write,
    input  gpu_pkg::data_t                       dcr_data,
    input  logic [`GPU_NUM_CORES-1:0]            prog_read_ready,
    input  gpu_pkg::instr_t [`GPU_NUM_CORES-1:0] prog_read_data,
    input  logic                                 mem_ready,
    input  gpu_pkg::data_t                       mem_rdata,
    output logic                                 done,
    output logic [`GPU_NUM_CORES-1:0]            prog_read_valid,
    output gpu_pkg::paddr_t [`GPU_NUM_CORES-1:0] prog_read_address,
    output logic                                 mem_valid,
    output logic                                 mem_write,
    output gpu_pkg::daddr_t                      mem_address,
    output gpu_pkg::data_t                       mem_wdata
);
    import gpu_pkg::*;

    localparam int TPB = `GPU_THREADS_PER_BLOCK;

    logic [`GPU_NUM_CORES-1:0]        core_start;
    logic [`GPU_NUM_CORES-1:0]        core_done;
    block_id_t [`GPU_NUM_CORES-1:0]   core_block_id;
    lane_count_t [`GPU_NUM_CORES-1:0] core_thread_count;

    // Lane n belongs to core n / TPB
    logic [`GPU_NUM_LANES-1:0]        lane_valid;
    logic [`GPU_NUM_LANES-1:0]        lane_write;
    logic [`GPU_NUM_LANES-1:0]        lane_ready;
    daddr_t [`GPU_NUM_LANES-1:0]      lane_address;
    data_t [`GPU_NUM_LANES-1:0]       lane_wdata;
    data_t [`GPU_NUM_LANES-1:0]       lane_rdata;

    block_dispatch u_dispatch (
        .clk               (clk),
        .arst_n            (arst_n),
        .start             (start),
        .dcr_write         (dcr_write),
        .dcr_data          (dcr_data),
        .core_done         (core_done),
        .core_start        (core_start),
        .core_block_id     (core_block_id),
        .core_thread_count (core_thread_count),
        .done              (done)
    );

    for (genvar c = 0; c < `GPU_NUM_CORES; c++) begin : g_core
        compute_core u_core (
            .clk               (clk),
            .arst_n            (arst_n),
            .start             (core_start[c]),
            .block_id          (core_block_id[c]),
            .thread_count      (core_thread_count[c]),
            .prog_read_ready   (prog_read_ready[c]),
            .prog_read_data    (prog_read_data[c]),
            .lane_ready        (lane_ready[c*TPB +: TPB]),
            .lane_rdata        (lane_rdata[c*TPB +: TPB]),
            .done              (core_done[c]),
            .prog_read_valid   (prog_read_valid[c]),
            .prog_read_address (prog_read_address[c]),
            .lane_valid        (lane_valid[c*TPB +: TPB]),
            .lane_write        (lane_write[c*TPB +: TPB]),
            .lane_address      (lane_address[c*TPB +: TPB]),
            .lane_wdata        (lane_wdata[c*TPB +: TPB])
        );
    end

    data_mem_arbiter u_arbiter (
        .clk          (clk),
        .arst_n       (arst_n),
        .lane_valid   (lane_valid),
        .lane_write   (lane_write),
        .lane_address (lane_address),
        .lane_wdata   (lane_wdata),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .lane_ready   (lane_ready),
        .lane_rdata   (lane_rdata),
        .mem_valid    (mem_valid),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata)
    );

endmodule

//--- test/gpu_mem_model.sv
// One outstanding request per channel, and the load port must stay idle while the GPU runs
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module gpu_mem_model (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 load_en,
    input  logic                                 load_prog,
    input  gpu_pkg::paddr_t                      load_addr,
    input  gpu_pkg::instr_t                      load_data,
    input  logic [`GPU_NUM_CORES-1:0]            prog_read_valid,
    input  gpu_pkg::paddr_t [`GPU_NUM_CORES-1:0] prog_read_address,
    output logic [`GPU_NUM_CORES-1:0]            prog_read_ready,
    output gpu_pkg::instr_t [`GPU_NUM_CORES-1:0] prog_read_data,
    input  logic                                 mem_valid,
    input  logic                                 mem_write,
    input  gpu_pkg::daddr_t                      mem_address,
    input  gpu_pkg::data_t                       mem_wdata,
    output logic                                 mem_ready,
    output gpu_pkg::data_t                       mem_rdata
);
    import gpu_pkg::*;

    instr_t     prog_mem [2**`GPU_PROG_ADDR_BITS];
    data_t      data_mem [2**`GPU_DATA_ADDR_BITS];

    logic       prog_busy [`GPU_NUM_CORES];
    logic [1:0] prog_delay [`GPU_NUM_CORES];
    logic       data_busy;
    logic [1:0] data_delay;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_read_ready <= '0;
            mem_ready       <= 1'b0;
            data_busy       <= 1'b0;
            data_delay      <= '0;
            for (int c = 0; c < `GPU_NUM_CORES; c++) begin
                prog_busy[c]  <= 1'b0;
                prog_delay[c] <= '0;
            end
        end else begin
            prog_read_ready <= '0;
            mem_ready       <= 1'b0;
            if (load_en && load_prog) begin
                prog_mem[load_addr] <= load_data;
            end else if (load_en) begin
                data_mem[load_addr] <= data_t'(load_data);
            end
            // A request is first seen, then answered 1 to 4 cycles later
            for (int c = 0; c < `GPU_NUM_CORES; c++) begin
                if (prog_read_valid[c] && !prog_read_ready[c]) begin
                    if (!prog_busy[c]) begin
                        prog_busy[c]  <= 1'b1;
                        prog_delay[c] <= 2'($urandom_range(3, 0));
                    end else if (prog_delay[c] == '0) begin
                        prog_busy[c]       <= 1'b0;
                        prog_read_ready[c] <= 1'b1;
                        prog_read_data[c]  <= prog_mem[prog_read_address[c]];
                    end else begin
                        prog_delay[c] <= prog_delay[c] - 1'b1;
                    end
                end
            end
            if (mem_valid && !mem_ready) begin
                if (!data_busy) begin
                    data_busy  <= 1'b1;
                    data_delay <= 2'($urandom_range(3, 0));
                end else if (data_delay == '0) begin
                    data_busy <= 1'b0;
                    mem_ready <= 1'b1;
                    mem_rdata <= data_mem[mem_address];
                    if (mem_write) begin
                        data_mem[mem_address] <= mem_wdata;
                    end
                end else begin
                    data_delay <= data_delay - 1'b1;
                end
            end
        end
    end

endmodule

//--- test/gpu_tb.sv
// Kernels read a at i and b at 32 + i and write 64 + i, so thread counts stay at or below 32
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module gpu_tb;
    import gpu_pkg::*;

    localparam int NUM_TESTS = 7;
    localparam int PROG_LEN  = 12;
    localparam int TPB       = `GPU_THREADS_PER_BLOCK;
    localparam int MAX_CYC   = NUM_TESTS * 5000;

    // Kernel 0 is vector add with index from CONST 4, kernel 1 is a * b - i with index from r14
    localparam instr_t KERNEL_ROM [2][PROG_LEN] = '{
        '{16'h9004, 16'h51D0, 16'h311F, 16'h9220, 16'h3312, 16'h7410,
          16'h7530, 16'h3645, 16'h9740, 16'h3817, 16'h8086, 16'hF000},
        '{16'h51DE, 16'h311F, 16'h9220, 16'h3312, 16'h7410, 16'h7530,
          16'h5645, 16'h4661, 16'h9740, 16'h3817, 16'h8086, 16'hF000}
    };

    // Test table with kernel, thread count and data seed per entry
    localparam int    KERNEL_TAB [NUM_TESTS] = '{0, 0, 0, 1, 0, 1, 0};
    localparam int    THREAD_TAB [NUM_TESTS] = '{8, 6, 13, 8, 0, 12, 16};
    localparam data_t SEED_TAB [NUM_TESTS]   = '{8'h11, 8'h5a, 8'h23, 8'h77, 8'h3c, 8'h90, 8'hc5};

    logic                        clk;
    logic                        arst_n;
    logic                        start;
    logic                        dcr_write;
    data_t                       dcr_data;
    logic                        done;
    logic                        load_en;
    logic                        load_prog;
    paddr_t                      load_addr;
    instr_t                      load_data;
    logic [`GPU_NUM_CORES-1:0]   prog_read_valid;
    logic [`GPU_NUM_CORES-1:0]   prog_read_ready;
    paddr_t [`GPU_NUM_CORES-1:0] prog_read_address;
    instr_t [`GPU_NUM_CORES-1:0] prog_read_data;
    logic                        mem_valid;
    logic                        mem_write;
    logic                        mem_ready;
    daddr_t                      mem_address;
    data_t                       mem_wdata;
    data_t                       mem_rdata;

    data_t                       ref_mem [256];
    int                          errors;

    gpu UUT (
        .clk               (clk),
        .arst_n            (arst_n),
        .start             (start),
        .dcr_write         (dcr_write),
        .dcr_data          (dcr_data),
        .prog_read_ready   (prog_read_ready),
        .prog_read_data    (prog_read_data),
        .mem_ready         (mem_ready),
        .mem_rdata         (mem_rdata),
        .done              (done),
        .prog_read_valid   (prog_read_valid),
        .prog_read_address (prog_read_address),
        .mem_valid         (mem_valid),
        .mem_write         (mem_write),
        .mem_address       (mem_address),
        .mem_wdata         (mem_wdata)
    );

    gpu_mem_model mem_model (
        .clk               (clk),
        .arst_n            (arst_n),
        .load_en           (load_en),
        .load_prog         (load_prog),
        .load_addr         (load_addr),
        .load_data         (load_data),
        .prog_read_valid   (prog_read_valid),
        .prog_read_address (prog_read_address),
        .prog_read_ready   (prog_read_ready),
        .prog_read_data    (prog_read_data),
        .mem_valid         (mem_valid),
        .mem_write         (mem_write),
        .mem_address       (mem_address),
        .mem_wdata         (mem_wdata),
        .mem_ready         (mem_ready),
        .mem_rdata         (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 37 is odd, so every address gets its own base value
    function automatic data_t fill_value(input int addr, input data_t seed);
        return data_t'(addr * 37) ^ seed;
    endfunction

    // Unused program words are NOPs carrying their own address
    task automatic load_memories(input int kernel, input data_t seed);
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_prog <= 1'b1;
            load_addr <= paddr_t'(a);
            load_data <= (a < PROG_LEN) ? KERNEL_ROM[kernel][a] : {8'h00, 8'(a)};
        end
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            load_prog  <= 1'b0;
            load_addr  <= paddr_t'(a);
            load_data  <= {8'h00, fill_value(a, seed)};
            ref_mem[a] = fill_value(a, seed);
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic compute_reference(input int kernel, input int count);
        int    bid;
        int    tid;
        int    dim;
        int    idx;
        data_t a;
        data_t b;
        for (int t = 0; t < count; t++) begin
            bid = t / TPB;
            tid = t % TPB;
            // Only the last block can be partial, and r14 then holds the remainder
            dim = (bid == (count - 1) / TPB && count % TPB != 0) ? count % TPB : TPB;
            idx = (kernel == 1) ? bid * dim + tid : bid * TPB + tid;
            a   = ref_mem[idx];
            b   = ref_mem[32 + idx];
            if (kernel == 1) begin
                ref_mem[64 + idx] = data_t'(a * b) - data_t'(idx);
            end else begin
                ref_mem[64 + idx] = a + b;
            end
        end
    endtask

    task automatic check_memory(input int test);
        for (int a = 0; a < 256; a++) begin
            if (mem_model.data_mem[a] !== ref_mem[a]) begin
                errors++;
                $display("Error: test %0d data_mem[%02h] got %02h expected %02h",
                         test, a, mem_model.data_mem[a], ref_mem[a]);
            end
        end
    endtask

    initial begin
        errors    = 0;
        arst_n    = 1'b0;
        start     = 1'b0;
        dcr_write = 1'b0;
        dcr_data  = '0;
        load_en   = 1'b0;
        load_prog = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(32'hcaa9_1f03));
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            load_memories(KERNEL_TAB[t], SEED_TAB[t]);
            compute_reference(KERNEL_TAB[t], THREAD_TAB[t]);
            // Done is still up from the previous run, but low after reset
            @(negedge clk);
            if (done !== (t > 0)) begin
                errors++;
                $display("Error: test %0d done before start got %h expected %h", t, done, t > 0);
            end
            @(posedge clk);
            dcr_write <= 1'b1;
            dcr_data  <= data_t'(THREAD_TAB[t]);
            @(posedge clk);
            dcr_write <= 1'b0;
            start     <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
            if (done !== 1'b0) begin
                errors++;
                $display("Error: test %0d done after start got %h expected 0", t, done);
            end
            while (done !== 1'b1) begin
                @(negedge clk);
            end
            check_memory(t);
        end

        $display("Run finished with %0d errors over %0d tests", errors, NUM_TESTS);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Limit covers memory loading and the slowest run of each entry
    initial begin
        repeat (MAX_CYC) @(posedge clk);
        $display("Timeout: done did not rise within %0d cycles", MAX_CYC);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+logic
logic/gpu_pkg.sv
logic/block_dispatch.sv
logic/data_mem_arbiter.sv
logic/compute_core.sv
logic/gpu.sv
test/gpu_mem_model.sv
test/gpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= gpu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
